// ==== verilog.f ====
hw/sweepAcqPkg.sv
hw/acqDataFifo.sv
hw/scParamLoader.sv
hw/sweepAcqControl.sv
hw/sweepAcqTop.sv
verification/sweepAcq_checker.sv
verification/sweepAcqTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sweepAcqTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/sweepAcqTb.sv ====
`timescale 1ns/1ns

module sweepAcqTb;
    import sweepAcqPkg::*;

    localparam int WordsPerFire = 10;
    localparam int SettleCycles = 20;
    localparam int MaxGap = 8;

    logic                 Clk;
    logic                 reset_n;
    logic                 SweepStart;
    logic [DacWidth-1:0]  StartDac;
    logic [DacWidth-1:0]  EndDac;
    logic [15:0]          MaxPackageNumber;
    logic [DataWidth-1:0] ParallelData;
    logic                 ParallelDataEn;
    logic                 SingleAcqStart;
    logic                 OneDacDone;
    logic                 AcqDone;
    logic [DataWidth-1:0] SweepData;
    logic                 SweepDataEn;
    logic                 ScSerialClk;
    logic                 ScSerialData;

    // Bit 16 set means the next front-end word is expected
    logic [16:0]          frameQ[$];
    logic [DataWidth-1:0] dataQ[$];
    logic [DacWidth-1:0]  serialCodeQ[$];

    int                   streamErrors;
    int                   controlErrors;
    int                   oneDacCount;
    int                   acqDoneCount;
    int                   serialBitIdx;
    logic [DacWidth-1:0]  serialBits;
    logic                 prevSerialClk;

    sweepAcqTop #(
        .WordsPerFire (WordsPerFire),
        .SettleCycles (SettleCycles)
    ) u_sweepAcqTop (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .StartDac         (StartDac),
        .EndDac           (EndDac),
        .MaxPackageNumber (MaxPackageNumber),
        .ParallelData     (ParallelData),
        .ParallelDataEn   (ParallelDataEn),
        .SingleAcqStart   (SingleAcqStart),
        .OneDacDone       (OneDacDone),
        .AcqDone          (AcqDone),
        .SweepData        (SweepData),
        .SweepDataEn      (SweepDataEn),
        .ScSerialClk      (ScSerialClk),
        .ScSerialData     (ScSerialData)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    ////////////////////////////////////////
    // Checking tasks
    ////////////////////////////////////////
    task automatic checkStreamWord(input logic [DataWidth-1:0] word);
        logic [16:0]          entry;
        logic [DataWidth-1:0] expected;
        if (frameQ.size() == 0) begin
            streamErrors++;
            $display("Stream word %h at %0t ns came when no word was expected", word, $time);
        end else begin
            entry = frameQ.pop_front();
            if (entry[16] && dataQ.size() == 0) begin
                streamErrors++;
                $display("Data word %h at %0t ns came before the front end sent it",
                         word, $time);
            end else begin
                expected = entry[16] ? dataQ.pop_front() : entry[15:0];
                assert (word == expected) else begin
                    streamErrors++;
                    $display("Mismatch at %0t ns: stream word %h, expected %h",
                             $time, word, expected);
                end
            end
        end
    endtask

    // Reversed code sent MSB first puts code bit 0 on the line first
    task automatic checkSerialCode(input logic [DacWidth-1:0] bits);
        logic [DacWidth-1:0] code;
        if (serialCodeQ.size() == 0) begin
            controlErrors++;
            $display("Serial load at %0t ns with no DAC code expected", $time);
        end else begin
            code = serialCodeQ.pop_front();
            assert (bits == code) else begin
                controlErrors++;
                $display("Mismatch at %0t ns: serial bits LSB first %h, code %h",
                         $time, bits, code);
            end
        end
    endtask

    task automatic checkResetState();
        assert (!SweepDataEn && !SingleAcqStart && !OneDacDone && !AcqDone && !ScSerialClk &&
                !u_sweepAcqTop.scLoad && !u_sweepAcqTop.fifoRdEn) else begin
            controlErrors++;
            $display("Mismatch at %0t ns: control outputs not all low after reset", $time);
        end
    endtask

    // Sampled on the falling edge, away from the DUT's register updates
    always @(negedge Clk) begin
        if (reset_n && SweepDataEn) begin
            checkStreamWord(SweepData);
        end
        if (reset_n && OneDacDone) begin
            oneDacCount++;
        end
        if (reset_n && AcqDone) begin
            acqDoneCount++;
            assert (frameQ.size() == 0) else begin
                controlErrors++;
                $display("AcqDone pulsed at %0t ns before the tail word", $time);
            end
        end
        if (reset_n && ScSerialClk && !prevSerialClk) begin
            serialBits = {ScSerialData, serialBits[DacWidth-1:1]};
            if (serialBitIdx == DacWidth - 1) begin
                checkSerialCode(serialBits);
                serialBitIdx = 0;
            end else begin
                serialBitIdx++;
            end
        end
        prevSerialClk = ScSerialClk;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic driveFrontEnd(input int codes, input int fires);
        int gap;
        for (int c = 0; c < codes; c++) begin
            while (!SingleAcqStart) begin
                @(negedge Clk);
            end
            for (int f = 0; f < fires; f++) begin
                gap = $urandom_range(MaxGap, 0);
                repeat (gap) @(negedge Clk);
                for (int w = 0; w < WordsPerFire; w++) begin
                    ParallelData = DataWidth'($urandom);
                    ParallelDataEn = 1'b1;
                    dataQ.push_back(ParallelData);
                    @(negedge Clk);
                end
                ParallelDataEn = 1'b0;
            end
            while (SingleAcqStart) begin
                @(negedge Clk);
            end
        end
    endtask

    task automatic waitAcqDone();
        while (!AcqDone) begin
            @(negedge Clk);
        end
    endtask

    task automatic runSweep(input int startCode, input int endCode, input int fires);
        int codes;
        codes = endCode - startCode + 1;
        frameQ.push_back({1'b0, HeaderWord});
        for (int c = startCode; c <= endCode; c++) begin
            frameQ.push_back({1'b0, DacMarkerTag, 2'b00, DacWidth'(c)});
            serialCodeQ.push_back(DacWidth'(c));
            repeat (WordsPerFire * fires) begin
                frameQ.push_back({1'b1, 16'h0000});
            end
        end
        frameQ.push_back({1'b0, TailWord});
        oneDacCount = 0;
        acqDoneCount = 0;
        StartDac = DacWidth'(startCode);
        EndDac = DacWidth'(endCode);
        MaxPackageNumber = 16'(fires);
        SweepStart = 1'b1;
        @(negedge Clk);
        SweepStart = 1'b0;
        fork
            driveFrontEnd(codes, fires);
            waitAcqDone();
        join
        // Any word in this quiet period is unexpected
        repeat (20) @(negedge Clk);
        assert (oneDacCount == codes && acqDoneCount == 1) else begin
            controlErrors++;
            $display("Mismatch at %0t ns: OneDacDone %0d times, AcqDone %0d times",
                     $time, oneDacCount, acqDoneCount);
        end
        assert (frameQ.size() == 0 && dataQ.size() == 0 && serialCodeQ.size() == 0) else begin
            controlErrors++;
            $display("Sweep %0d to %0d ended with words or loads still missing",
                     startCode, endCode);
        end
    endtask

    function automatic int sweepCycles(input int codes, input int fires);
        return codes * ((2 * DacWidth + 8) + SettleCycles +
                        fires * (WordsPerFire * 4 + MaxGap + 4)) + 24;
    endfunction

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge Clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Regression failed");
        $finish;
    endtask

    initial begin
        int randStart;
        int randCodes;
        int randFires;
        int limit;
        int checkerErrors;
        void'($urandom(37));
        reset_n = 1'b0;
        SweepStart = 1'b0;
        StartDac = '0;
        EndDac = '0;
        MaxPackageNumber = '0;
        ParallelData = '0;
        ParallelDataEn = 1'b0;
        streamErrors = 0;
        controlErrors = 0;
        oneDacCount = 0;
        acqDoneCount = 0;
        serialBitIdx = 0;
        serialBits = '0;
        prevSerialClk = 1'b0;
        randStart = $urandom_range(1000, 0);
        randCodes = $urandom_range(6, 1);
        randFires = $urandom_range(3, 1);
        limit = 2 * (16 + sweepCycles(1, 3) + sweepCycles(4, 2) +
                     sweepCycles(randCodes, randFires));
        fork
            watchdog(limit);
        join_none

        repeat (16) @(posedge Clk);
        @(negedge Clk);
        reset_n = 1'b1;
        @(negedge Clk);
        checkResetState();

        runSweep(300, 300, 3);
        runSweep(5, 8, 2);
        runSweep(randStart, randStart + randCodes - 1, randFires);

        checkerErrors = u_sweepAcqTop.u_sweepAcqControl.u_sweepAcqChecker.failCount;
        $display("Errors: stream %0d, control %0d, checker %0d",
                 streamErrors, controlErrors, checkerErrors);
        if (streamErrors + controlErrors + checkerErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verification/sweepAcq_checker.sv ====
`timescale 1ns/1ns

module sweepAcqChecker (
    input logic                              Clk,
    input logic                              reset_n,
    input sweepAcqPkg::sweepStateT           state,
    input logic                              SweepStart,
    input logic [sweepAcqPkg::DataWidth-1:0] SweepData,
    input logic                              SweepDataEn,
    input logic                              ScLoad,
    input logic                              FifoRdEn,
    input logic                              SingleAcqStart,
    input logic                              OneDacDone,
    input logic                              AcqDone
);
    import sweepAcqPkg::*;

    int failCount = 0;

    ////////////////////////////////////////
    // Stream output
    ////////////////////////////////////////
    streamEnSingle: assert property (@(posedge Clk) disable iff (!reset_n)
        SweepDataEn |=> !SweepDataEn)
        else begin
            failCount++;
            $error("SweepDataEn held high for two cycles");
        end

    // Idle without a start request keeps the stream quiet
    idleQuiet: assert property (@(posedge Clk) disable iff (!reset_n)
        (state == Idle && !SweepStart) |=> !SweepDataEn)
        else begin
            failCount++;
            $error("Stream word emitted while idle");
        end

    // Load strobe goes out with the marker word
    loadWithMarker: assert property (@(posedge Clk) disable iff (!reset_n)
        ScLoad |-> (SweepDataEn && SweepData[15:12] == DacMarkerTag && !SingleAcqStart))
        else begin
            failCount++;
            $error("ScLoad without a marker word or during acquisition");
        end

    ////////////////////////////////////////
    // Control pulses and levels
    ////////////////////////////////////////
    // Acquisition level stays low from the end of one code to the next start
    acqLowBetweenCodes: assert property (@(posedge Clk) disable iff (!reset_n)
        (state inside {Idle, HeaderOut, ParamOut, LoadParam, WaitLoadDone, Settle,
                       CheckAllDone, TailOut, AllDone}) |-> !SingleAcqStart)
        else begin
            failCount++;
            $error("SingleAcqStart high between codes");
        end

    oneDacPulse: assert property (@(posedge Clk) disable iff (!reset_n)
        OneDacDone |=> !OneDacDone)
        else begin
            failCount++;
            $error("OneDacDone longer than one cycle");
        end

    acqDonePulse: assert property (@(posedge Clk) disable iff (!reset_n)
        AcqDone |=> !AcqDone)
        else begin
            failCount++;
            $error("AcqDone longer than one cycle");
        end

    fifoReadPulse: assert property (@(posedge Clk) disable iff (!reset_n)
        FifoRdEn |=> !FifoRdEn)
        else begin
            failCount++;
            $error("FifoRdEn longer than one cycle");
        end

endmodule

bind sweepAcqControl sweepAcqChecker u_sweepAcqChecker (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .state          (state),
    .SweepStart     (SweepStart),
    .SweepData      (SweepData),
    .SweepDataEn    (SweepDataEn),
    .ScLoad         (ScLoad),
    .FifoRdEn       (FifoRdEn),
    .SingleAcqStart (SingleAcqStart),
    .OneDacDone     (OneDacDone),
    .AcqDone        (AcqDone)
);

// ==== hw/sweepAcqTop.sv ====
`timescale 1ns/1ns

module sweepAcqTop #(
    parameter int WordsPerFire = 10,
    parameter int SettleCycles = 40000,
    parameter int FifoDepth = 32
) (
    input  logic                              Clk,
    input  logic                              reset_n,
    input  logic                              SweepStart,
    input  logic [sweepAcqPkg::DacWidth-1:0]  StartDac,
    input  logic [sweepAcqPkg::DacWidth-1:0]  EndDac,
    input  logic [15:0]                       MaxPackageNumber,
    input  logic [sweepAcqPkg::DataWidth-1:0] ParallelData,
    input  logic                              ParallelDataEn,
    output logic                              SingleAcqStart,
    output logic                              OneDacDone,
    output logic                              AcqDone,
    output logic [sweepAcqPkg::DataWidth-1:0] SweepData,
    output logic                              SweepDataEn,
    output logic                              ScSerialClk,
    output logic                              ScSerialData
);
    import sweepAcqPkg::*;

    logic [DataWidth-1:0] fifoData;
    logic                 fifoRdEn;
    logic [DacWidth-1:0]  scDacWord;
    logic                 scLoad;
    logic                 scConfigDone;

    ////////////////////////////////////////
    // Front-end data buffer
    ////////////////////////////////////////
    acqDataFifo #(
        .FifoDepth (FifoDepth)
    ) u_acqDataFifo (
        .Clk     (Clk),
        .reset_n (reset_n),
        .WrData  (ParallelData),
        .WrEn    (ParallelDataEn),
        .RdEn    (fifoRdEn),
        .RdData  (fifoData),
        .Empty   (),
        .Full    ()
    );

    // Threshold DAC serial load
    scParamLoader u_scParamLoader (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .Load       (scLoad),
        .DacWord    (scDacWord),
        .SerialClk  (ScSerialClk),
        .SerialData (ScSerialData),
        .ConfigDone (scConfigDone)
    );

    ////////////////////////////////////////
    // Sweep sequencing and stream output
    ////////////////////////////////////////
    sweepAcqControl #(
        .WordsPerFire (WordsPerFire),
        .SettleCycles (SettleCycles)
    ) u_sweepAcqControl (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .StartDac         (StartDac),
        .EndDac           (EndDac),
        .MaxPackageNumber (MaxPackageNumber),
        .ParallelDataEn   (ParallelDataEn),
        .FifoData         (fifoData),
        .FifoRdEn         (fifoRdEn),
        .ScDacWord        (scDacWord),
        .ScLoad           (scLoad),
        .ScConfigDone     (scConfigDone),
        .SingleAcqStart   (SingleAcqStart),
        .OneDacDone       (OneDacDone),
        .AcqDone          (AcqDone),
        .SweepData        (SweepData),
        .SweepDataEn      (SweepDataEn)
    );

endmodule

// ==== hw/sweepAcqControl.sv ====
`timescale 1ns/1ns

module sweepAcqControl #(
    parameter int WordsPerFire = 10,
    parameter int SettleCycles = 40000
) (
    input  logic                              Clk,
    input  logic                              reset_n,
    input  logic                              SweepStart,
    input  logic [sweepAcqPkg::DacWidth-1:0]  StartDac,
    input  logic [sweepAcqPkg::DacWidth-1:0]  EndDac,
    input  logic [15:0]                       MaxPackageNumber,
    input  logic                              ParallelDataEn,
    input  logic [sweepAcqPkg::DataWidth-1:0] FifoData,
    output logic                              FifoRdEn,
    output logic [sweepAcqPkg::DacWidth-1:0]  ScDacWord,
    output logic                              ScLoad,
    input  logic                              ScConfigDone,
    output logic                              SingleAcqStart,
    output logic                              OneDacDone,
    output logic                              AcqDone,
    output logic [sweepAcqPkg::DataWidth-1:0] SweepData,
    output logic                              SweepDataEn
);
    import sweepAcqPkg::*;

    localparam int SettleWidth = $clog2(SettleCycles + 1);
    localparam int WordWidth = $clog2(WordsPerFire + 1);

    sweepStateT             state;
    logic [DacWidth-1:0]    dacCode;
    logic [SettleWidth-1:0] settleCount;
    logic [WordWidth-1:0]   readCount;
    logic [15:0]            fireCount;
    logic [WordWidth-1:0]   fireWordCount;
    logic [7:0]             pendingFires;
    logic                   fireComplete;
    logic                   fireTake;

    // Front end sends the code LSB first, so the word is flipped
    function automatic logic [DacWidth-1:0] bitReverse(input logic [DacWidth-1:0] code);
        logic [DacWidth-1:0] result;
        for (int i = 0; i < DacWidth; i++) begin
            result[i] = code[DacWidth-1-i];
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Fire counter
    ////////////////////////////////////////
    assign fireComplete = ParallelDataEn && (fireWordCount == WordWidth'(WordsPerFire - 1));
    assign fireTake = (state == WaitFire) && (pendingFires != '0);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            fireWordCount <= '0;
            pendingFires <= '0;
        end else begin
            if (fireComplete) begin
                fireWordCount <= '0;
            end else if (ParallelDataEn) begin
                fireWordCount <= fireWordCount + 1'b1;
            end
            // Several fires may sit in the FIFO at once
            case ({fireComplete, fireTake})
                2'b10:   pendingFires <= pendingFires + 1'b1;
                2'b01:   pendingFires <= pendingFires - 1'b1;
                default: pendingFires <= pendingFires;
            endcase
        end
    end

    ////////////////////////////////////////
    // Sweep state machine
    ////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= Idle;
            dacCode <= '0;
            settleCount <= '0;
            readCount <= '0;
            fireCount <= '0;
            FifoRdEn <= 1'b0;
            ScDacWord <= '0;
            ScLoad <= 1'b0;
            SingleAcqStart <= 1'b0;
            OneDacDone <= 1'b0;
            AcqDone <= 1'b0;
            SweepData <= '0;
            SweepDataEn <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    AcqDone <= 1'b0;
                    dacCode <= StartDac;
                    fireCount <= '0;
                    // No restart in the cycle that reports the finished sweep
                    if (SweepStart && !AcqDone) begin
                        SweepData <= HeaderWord;
                        state <= HeaderOut;
                    end
                end
                HeaderOut: begin
                    SweepDataEn <= 1'b1;
                    state <= ParamOut;
                end
                ParamOut: begin
                    SweepDataEn <= 1'b0;
                    SweepData <= {DacMarkerTag, 2'b00, dacCode};
                    ScDacWord <= bitReverse(dacCode);
                    state <= LoadParam;
                end
                LoadParam: begin
                    // Marker word and load strobe leave together
                    SweepDataEn <= 1'b1;
                    ScLoad <= 1'b1;
                    state <= WaitLoadDone;
                end
                WaitLoadDone: begin
                    SweepDataEn <= 1'b0;
                    ScLoad <= 1'b0;
                    if (ScConfigDone) begin
                        settleCount <= '0;
                        state <= Settle;
                    end
                end
                Settle: begin
                    if (settleCount == SettleWidth'(SettleCycles - 1)) begin
                        state <= StartAcq;
                    end else begin
                        settleCount <= settleCount + 1'b1;
                    end
                end
                StartAcq: begin
                    SingleAcqStart <= 1'b1;
                    fireCount <= '0;
                    state <= WaitFire;
                end
                WaitFire: begin
                    if (fireTake) begin
                        FifoRdEn <= 1'b1;
                        readCount <= '0;
                        state <= ReadWord;
                    end
                end
                ReadWord: begin
                    FifoRdEn <= 1'b0;
                    SweepDataEn <= 1'b0;
                    state <= WaitWord;
                end
                WaitWord: begin
                    // FIFO read register is valid now
                    SweepData <= FifoData;
                    state <= OutWord;
                end
                OutWord: begin
                    SweepDataEn <= 1'b1;
                    if (readCount < WordWidth'(WordsPerFire - 1)) begin
                        FifoRdEn <= 1'b1;
                        readCount <= readCount + 1'b1;
                        state <= ReadWord;
                    end else begin
                        state <= CheckDacDone;
                    end
                end
                CheckDacDone: begin
                    SweepDataEn <= 1'b0;
                    if (fireCount + 16'd1 < MaxPackageNumber) begin
                        fireCount <= fireCount + 1'b1;
                        state <= WaitFire;
                    end else begin
                        fireCount <= '0;
                        SingleAcqStart <= 1'b0;
                        OneDacDone <= 1'b1;
                        state <= CheckAllDone;
                    end
                end
                CheckAllDone: begin
                    OneDacDone <= 1'b0;
                    if (dacCode < EndDac) begin
                        dacCode <= dacCode + 1'b1;
                        state <= ParamOut;
                    end else begin
                        SweepData <= TailWord;
                        state <= TailOut;
                    end
                end
                TailOut: begin
                    SweepDataEn <= 1'b1;
                    state <= AllDone;
                end
                AllDone: begin
                    SweepDataEn <= 1'b0;
                    AcqDone <= 1'b1;
                    state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

// ==== hw/scParamLoader.sv ====
`timescale 1ns/1ns

module scParamLoader (
    input  logic                             Clk,
    input  logic                             reset_n,
    input  logic                             Load,
    input  logic [sweepAcqPkg::DacWidth-1:0] DacWord,
    output logic                             SerialClk,
    output logic                             SerialData,
    output logic                             ConfigDone
);
    import sweepAcqPkg::*;

    localparam int CountWidth = $clog2(DacWidth);

    loaderStateT           state;
    logic [DacWidth-1:0]   shiftReg;
    logic [CountWidth-1:0] bitCount;

    // MSB of the shift register is the line to the front end
    assign SerialData = shiftReg[DacWidth-1];

    ////////////////////////////////////////
    // Serializer
    ////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= LdIdle;
            shiftReg <= '0;
            bitCount <= '0;
            SerialClk <= 1'b0;
            ConfigDone <= 1'b0;
        end else begin
            case (state)
                LdIdle: begin
                    SerialClk <= 1'b0;
                    if (Load) begin
                        shiftReg <= DacWord;
                        bitCount <= CountWidth'(DacWidth - 1);
                        state <= LdShift;
                    end
                end
                LdShift: begin
                    // Low half then high half for every bit
                    SerialClk <= ~SerialClk;
                    if (SerialClk) begin
                        // Data moves on the falling edge of the serial clock
                        shiftReg <= {shiftReg[DacWidth-2:0], 1'b0};
                        if (bitCount == '0) begin
                            ConfigDone <= 1'b1;
                            state <= LdDone;
                        end else begin
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                LdDone: begin
                    ConfigDone <= 1'b0;
                    state <= LdIdle;
                end
                default: state <= LdIdle;
            endcase
        end
    end

endmodule

// ==== hw/acqDataFifo.sv ====
`timescale 1ns/1ns

module acqDataFifo #(
    parameter int FifoDepth = 32
) (
    input  logic                              Clk,
    input  logic                              reset_n,
    input  logic [sweepAcqPkg::DataWidth-1:0] WrData,
    input  logic                              WrEn,
    input  logic                              RdEn,
    output logic [sweepAcqPkg::DataWidth-1:0] RdData,
    output logic                              Empty,
    output logic                              Full
);
    import sweepAcqPkg::*;

    localparam int AddrWidth = $clog2(FifoDepth);

    logic [DataWidth-1:0] mem [FifoDepth];
    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth-1:0] rdPtr;
    logic [AddrWidth:0]   count;
    logic                 doWrite;
    logic                 doRead;

    assign Empty = (count == '0);
    assign Full = (count == (AddrWidth + 1)'(FifoDepth));

    // Writes to a full FIFO and reads from an empty one are dropped
    assign doWrite = WrEn && !Full;
    assign doRead = RdEn && !Empty;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == AddrWidth'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == AddrWidth'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= WrData;
        end
        if (doRead) begin
            RdData <= mem[rdPtr];
        end
    end

endmodule

// ==== hw/sweepAcqPkg.sv ====
package sweepAcqPkg;

    ////////////////////////////////////////
    // Word widths
    ////////////////////////////////////////
    localparam int DataWidth = 16;
    localparam int DacWidth = 10;

    ////////////////////////////////////////
    // Stream framing words
    ////////////////////////////////////////
    // ASCII "SA" opens a sweep
    localparam logic [DataWidth-1:0] HeaderWord = 16'h5341;
    localparam logic [DataWidth-1:0] TailWord = 16'hFF45;
    // Marker layout is tag, two zero bits, then the DAC code
    localparam logic [3:0] DacMarkerTag = 4'hD;

    ////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        Idle,
        HeaderOut,
        ParamOut,
        LoadParam,
        WaitLoadDone,
        Settle,
        StartAcq,
        WaitFire,
        ReadWord,
        WaitWord,
        OutWord,
        CheckDacDone,
        CheckAllDone,
        TailOut,
        AllDone
    } sweepStateT;

    typedef enum logic [1:0] {
        LdIdle,
        LdShift,
        LdDone
    } loaderStateT;

endpackage
